// ==== design/rvCorePkg.sv ====
// Shared types and constants for the RV32I integer execution core
`default_nettype none

package rvCorePkg;

    // --------------------------------------------------
    // Sizes fixed by the ISA
    // --------------------------------------------------
    localparam int xlen        = 32;
    localparam int regCount    = 32;
    localparam int regAddrBits = 5;

    // Nonzero register contents after reset
    localparam logic [xlen-1:0] resetX1  = 32'd7;
    localparam logic [xlen-1:0] resetX2  = 32'd7;
    localparam logic [xlen-1:0] resetX29 = 32'd252;

    // --------------------------------------------------
    // Major opcodes handled by the core
    // --------------------------------------------------
    typedef enum logic [6:0]
    {
        OpReg = 7'b0110011,     // Register-register
        OpImm = 7'b0010011,     // Register-immediate
        OpLui = 7'b0110111      // Load upper immediate
    } opcodeT;

    // ALU operations
    typedef enum logic [3:0]
    {
        AluAdd   = 4'd0,
        AluSub   = 4'd1,
        AluSll   = 4'd2,
        AluSlt   = 4'd3,
        AluSltu  = 4'd4,
        AluXor   = 4'd5,
        AluSrl   = 4'd6,
        AluSra   = 4'd7,
        AluOr    = 4'd8,
        AluAnd   = 4'd9,
        AluPassB = 4'd10        // Operand B straight through, for LUI
    } aluOpT;

endpackage

`default_nettype wire

// ==== design/AluUnit.sv ====
// Combinational 32-bit ALU for the RV32I integer operations
`timescale 1ns/10ps
`default_nettype none

module AluUnit
    import rvCorePkg::*;
(
    input  aluOpT                aluOp,
    input  wire logic [xlen-1:0] operandA,
    input  wire logic [xlen-1:0] operandB,
    output logic      [xlen-1:0] result
);

    logic [4:0] shamt;
    logic       lessSigned;
    logic       lessUnsigned;

    assign shamt        = operandB[4:0];    // Only the low five bits shift
    assign lessSigned   = ($signed(operandA) < $signed(operandB));
    assign lessUnsigned = (operandA < operandB);

    // --------------------------------------------------
    // Operation select
    // --------------------------------------------------
    always_comb
    begin
        case (aluOp)
            AluAdd:   result = operandA + operandB;
            AluSub:   result = operandA - operandB;
            AluSll:   result = operandA << shamt;
            AluSlt:   result = {{(xlen-1){1'b0}}, lessSigned};
            AluSltu:  result = {{(xlen-1){1'b0}}, lessUnsigned};
            AluXor:   result = operandA ^ operandB;
            AluSrl:   result = operandA >> shamt;
            AluSra:   result = $unsigned($signed(operandA) >>> shamt);  // Sign fill
            AluOr:    result = operandA | operandB;
            AluAnd:   result = operandA & operandB;
            AluPassB: result = operandB;
            default:  result = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== design/RegisterMemory.sv ====
// Register file, 32 x 32 bits, two synchronous reads, one write, x0 fixed at zero
`timescale 1ns/10ps
`default_nettype none

module RegisterMemory
    import rvCorePkg::*;
(
    input  wire logic                   clock,
    input  wire logic                   reset,
    input  wire logic [regAddrBits-1:0] rs1,        // First source index
    input  wire logic [regAddrBits-1:0] rs2,        // Second source index
    input  wire logic [regAddrBits-1:0] rsWrite,    // Destination index
    input  wire logic [xlen-1:0]        dataWrite,
    input  wire logic                   rWrite,
    output logic      [xlen-1:0]        outRS1,
    output logic      [xlen-1:0]        outRS2
);

    logic [xlen-1:0] registerArray [regCount];

    // --------------------------------------------------
    // Storage with reset image
    // --------------------------------------------------
    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            for (int idx = 0; idx < regCount; idx++)
            begin
                registerArray[idx] <= '0;
            end
            registerArray[1]  <= resetX1;
            registerArray[2]  <= resetX2;
            registerArray[29] <= resetX29;
        end
        else if (rWrite && (rsWrite != '0))     // x0 never written
        begin
            registerArray[rsWrite] <= dataWrite;
        end
    end

    // Read ports see the contents before this edge's write
    always_ff @(posedge clock)
    begin
        outRS1 <= registerArray[rs1];
        outRS2 <= registerArray[rs2];
    end

endmodule

`default_nettype wire

// ==== design/InstrDecoder.sv ====
// Instruction decoder producing registered execute-stage controls and immediate
`timescale 1ns/10ps
`default_nettype none

module InstrDecoder
    import rvCorePkg::*;
(
    input  wire logic                   clock,
    input  wire logic                   reset,
    input  wire logic [31:0]            instr,
    input  wire logic                   instrValid,
    output logic                        exValid,
    output aluOpT                       exAluOp,
    output logic      [xlen-1:0]        exImm,
    output logic                        exUseImm,
    output logic      [regAddrBits-1:0] exDest,
    output logic      [regAddrBits-1:0] exRs1,
    output logic      [regAddrBits-1:0] exRs2,
    output logic                        exIllegal
);

    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       altFunct;       // funct7 = 0100000
    logic       badFunct;       // funct7 neither 0 nor 0100000

    aluOpT           aluOpNext;
    logic [xlen-1:0] immNext;
    logic            useImmNext;
    logic            illegalNext;

    assign funct3   = instr[14:12];
    assign funct7   = instr[31:25];
    assign altFunct = (funct7 == 7'b0100000);
    assign badFunct = (funct7 != 7'b0000000) && !altFunct;

    // --------------------------------------------------
    // Operation and immediate decode
    // --------------------------------------------------
    always_comb
    begin
        aluOpNext   = AluAdd;
        immNext     = {{20{instr[31]}}, instr[31:20]};     // I-type
        useImmNext  = 1'b0;
        illegalNext = 1'b0;
        case (instr[6:0])
            OpReg, OpImm:
            begin
                useImmNext = (instr[6:0] == OpImm);
                case (funct3)
                    3'b000: aluOpNext = (altFunct && !useImmNext) ? AluSub : AluAdd;
                    3'b001: aluOpNext = AluSll;
                    3'b010: aluOpNext = AluSlt;
                    3'b011: aluOpNext = AluSltu;
                    3'b100: aluOpNext = AluXor;
                    3'b101: aluOpNext = altFunct ? AluSra : AluSrl;
                    3'b110: aluOpNext = AluOr;
                    default: aluOpNext = AluAnd;
                endcase
                // funct7 is immediate bits in OP-IMM except for the shifts
                if (!useImmNext || funct3 == 3'b001 || funct3 == 3'b101)
                begin
                    illegalNext = badFunct
                        || (altFunct && funct3 != 3'b101 && (useImmNext || funct3 != 3'b000));
                end
            end
            OpLui:
            begin
                aluOpNext  = AluPassB;
                immNext    = {instr[31:12], 12'b0};            // U-type
                useImmNext = 1'b1;
            end
            default: illegalNext = 1'b1;
        endcase
    end

    // Execute-stage registers
    always_ff @(posedge clock)
    begin
        if (reset)
            exValid <= 1'b0;
        else
            exValid <= instrValid;
        exAluOp   <= aluOpNext;
        exImm     <= immNext;
        exUseImm  <= useImmNext;
        exDest    <= instr[11:7];
        exRs1     <= instr[19:15];
        exRs2     <= instr[24:20];
        exIllegal <= illegalNext;
    end

endmodule

`default_nettype wire

// ==== design/ExecuteStage.sv ====
// Execute stage with operand bypass, ALU, write-back and retire registers
`timescale 1ns/10ps
`default_nettype none

module ExecuteStage
    import rvCorePkg::*;
(
    input  wire logic                   clock,
    input  wire logic                   reset,
    input  wire logic                   exValid,
    input  aluOpT                       exAluOp,
    input  wire logic [xlen-1:0]        exImm,
    input  wire logic                   exUseImm,
    input  wire logic [regAddrBits-1:0] exDest,
    input  wire logic [regAddrBits-1:0] exRs1,
    input  wire logic [regAddrBits-1:0] exRs2,
    input  wire logic                   exIllegal,
    input  wire logic [xlen-1:0]        outRS1,
    input  wire logic [xlen-1:0]        outRS2,
    output logic                        rWrite,
    output logic      [regAddrBits-1:0] rsWrite,
    output logic      [xlen-1:0]        dataWrite,
    output logic                        retireValid,
    output logic      [regAddrBits-1:0] retireDest,
    output logic      [xlen-1:0]        retireData,
    output logic                        retireIllegal
);

    // Record of the write made at the previous edge
    logic                   lastValid;
    logic [regAddrBits-1:0] lastDest;
    logic [xlen-1:0]        lastData;

    logic            hitA;
    logic            hitB;
    logic [xlen-1:0] operandA;
    logic [xlen-1:0] operandB;
    logic [xlen-1:0] aluResult;

    // --------------------------------------------------
    // Operand bypass and select
    // --------------------------------------------------
    assign hitA     = lastValid && (lastDest != '0) && (exRs1 == lastDest);
    assign hitB     = lastValid && (lastDest != '0) && (exRs2 == lastDest);
    assign operandA = hitA ? lastData : outRS1;
    assign operandB = exUseImm ? exImm : (hitB ? lastData : outRS2);

    AluUnit alu_i
    (
        .aluOp    (exAluOp),
        .operandA (operandA),
        .operandB (operandB),
        .result   (aluResult)
    );

    assign rWrite    = exValid && !exIllegal;
    assign rsWrite   = exDest;
    assign dataWrite = aluResult;

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            lastValid   <= 1'b0;
            retireValid <= 1'b0;
        end
        else
        begin
            lastValid   <= rWrite;      // Bubbles clear the record
            retireValid <= exValid;
        end
        lastDest      <= exDest;
        lastData      <= aluResult;
        retireDest    <= exDest;
        retireData    <= exIllegal ? '0 : aluResult;
        retireIllegal <= exIllegal;
    end

endmodule

`default_nettype wire

// ==== design/IntegerCore.sv ====
// RV32I integer core top level joining decoder, register file and execute stage
`timescale 1ns/10ps
`default_nettype none

module IntegerCore
    import rvCorePkg::*;
(
    input  wire logic                   clock,
    input  wire logic                   reset,
    input  wire logic [31:0]            instr,
    input  wire logic                   instrValid,
    output logic                        retireValid,
    output logic      [regAddrBits-1:0] retireDest,
    output logic      [xlen-1:0]        retireData,
    output logic                        retireIllegal
);

    // Execute-stage controls
    logic                   exValid;
    aluOpT                  exAluOp;
    logic [xlen-1:0]        exImm;
    logic                   exUseImm;
    logic [regAddrBits-1:0] exDest;
    logic [regAddrBits-1:0] exRs1;
    logic [regAddrBits-1:0] exRs2;
    logic                   exIllegal;

    // Register file ports
    logic [regAddrBits-1:0] rs1Field;
    logic [regAddrBits-1:0] rs2Field;
    logic [xlen-1:0]        outRS1;
    logic [xlen-1:0]        outRS2;
    logic                   rWrite;
    logic [regAddrBits-1:0] rsWrite;
    logic [xlen-1:0]        dataWrite;

    assign rs1Field = instr[19:15];
    assign rs2Field = instr[24:20];

    InstrDecoder decoder_i
    (
        .clock      (clock),
        .reset      (reset),
        .instr      (instr),
        .instrValid (instrValid),
        .exValid    (exValid),
        .exAluOp    (exAluOp),
        .exImm      (exImm),
        .exUseImm   (exUseImm),
        .exDest     (exDest),
        .exRs1      (exRs1),
        .exRs2      (exRs2),
        .exIllegal  (exIllegal)
    );

    RegisterMemory regFile_i
    (
        .clock     (clock),
        .reset     (reset),
        .rs1       (rs1Field),
        .rs2       (rs2Field),
        .rsWrite   (rsWrite),
        .dataWrite (dataWrite),
        .rWrite    (rWrite),
        .outRS1    (outRS1),
        .outRS2    (outRS2)
    );

    ExecuteStage execute_i
    (
        .clock         (clock),
        .reset         (reset),
        .exValid       (exValid),
        .exAluOp       (exAluOp),
        .exImm         (exImm),
        .exUseImm      (exUseImm),
        .exDest        (exDest),
        .exRs1         (exRs1),
        .exRs2         (exRs2),
        .exIllegal     (exIllegal),
        .outRS1        (outRS1),
        .outRS2        (outRS2),
        .rWrite        (rWrite),
        .rsWrite       (rsWrite),
        .dataWrite     (dataWrite),
        .retireValid   (retireValid),
        .retireDest    (retireDest),
        .retireData    (retireData),
        .retireIllegal (retireIllegal)
    );

endmodule

`default_nettype wire

// ==== verif/IntegerCoreTb.sv ====
// Vector-driven testbench for the RV32I integer execution core
`timescale 1ns/10ps
`default_nettype none

module IntegerCoreTb
    import rvCorePkg::*;
();

    localparam int clockPeriod = 20;
    localparam int vecCount    = 34;
    localparam int vecWords    = 4;     // Fields per vector line
    localparam int numPasses   = 2;     // Second pass adds random bubbles
    localparam int timeLimit   = (numPasses * (2 * vecCount + 10) + 20) * clockPeriod;

    logic                   clock = 1'b0;
    logic                   reset;
    logic [31:0]            instr;
    logic                   instrValid;
    logic                   retireValid;
    logic [regAddrBits-1:0] retireDest;
    logic [xlen-1:0]        retireData;
    logic                   retireIllegal;

    logic [35:0] vecMem [vecCount * vecWords];

    // Expected retires in issue order
    logic [regAddrBits-1:0] destQ [$];
    logic [xlen:0]          dataQ [$];      // Illegal flag on top
    int                     idQ   [$];

    logic [1:0] inFlight;       // Issue history of the last two cycles
    int         errorCount;
    int         retireCount;
    int         seed;

    IntegerCore dut_i
    (
        .clock         (clock),
        .reset         (reset),
        .instr         (instr),
        .instrValid    (instrValid),
        .retireValid   (retireValid),
        .retireDest    (retireDest),
        .retireData    (retireData),
        .retireIllegal (retireIllegal)
    );

    always #(clockPeriod / 2) clock = ~clock;

    // --------------------------------------------------
    // Retire check, called at each falling edge
    // --------------------------------------------------
    task automatic checkRetire();
        logic [regAddrBits-1:0] expDest;
        logic [xlen:0]          expWord;
        int                     vecId;
        if (inFlight[1])    // Issued two edges ago
        begin
            expDest = destQ.pop_front();
            expWord = dataQ.pop_front();
            vecId   = idQ.pop_front();
            if (!retireValid)
            begin
                $display("Vector %0d did not retire two edges after issue (%0t ns)",
                         vecId, $time);
                errorCount++;
            end
            else
            begin
                retireCount++;
                if (retireDest !== expDest)
                begin
                    $display("FAIL retireDest vector %0d expected 0x%02h got 0x%02h",
                             vecId, expDest, retireDest);
                    errorCount++;
                end
                if (retireData !== expWord[xlen-1:0])
                begin
                    $display("FAIL retireData vector %0d expected 0x%08h got 0x%08h",
                             vecId, expWord[xlen-1:0], retireData);
                    errorCount++;
                end
                if (retireIllegal !== expWord[xlen])
                begin
                    $display("FAIL retireIllegal vector %0d expected 0x%01h got 0x%01h",
                             vecId, expWord[xlen], retireIllegal);
                    errorCount++;
                end
            end
        end
        else if (retireValid)
        begin
            $display("Unexpected retire at %0t ns with no instruction in flight", $time);
            errorCount++;
        end
    endtask

    // One cycle: check what retired, then drive the next input
    task automatic stepCycle(input logic valid, input logic [31:0] word);
        @(negedge clock);
        checkRetire();
        instrValid = valid;
        instr      = word;
        inFlight   = {inFlight[0], valid};
    endtask

    task automatic runVector(input int vecId);
        int base;
        base = vecId * vecWords;
        stepCycle(!vecMem[base + 1][0], vecMem[base][31:0]);
        if (!vecMem[base + 1][0])
        begin
            destQ.push_back(vecMem[base + 2][regAddrBits-1:0]);
            dataQ.push_back(vecMem[base + 3][xlen:0]);
            idQ.push_back(vecId);
        end
    endtask

    task automatic applyReset();
        @(negedge clock);
        reset      = 1'b1;
        instrValid = 1'b0;
        instr      = '0;
        repeat (2) @(posedge clock);
        @(negedge clock);
        reset    = 1'b0;
        inFlight = '0;
        destQ.delete();
        dataQ.delete();
        idQ.delete();
    endtask

    // --------------------------------------------------
    // Main sequence
    // --------------------------------------------------
    initial
    begin
        reset       = 1'b1;
        instr       = '0;
        instrValid  = 1'b0;
        inFlight    = '0;
        errorCount  = 0;
        retireCount = 0;
        seed        = 32'h04a6_f39b;
        for (int i = 0; i < vecCount * vecWords; i++)
        begin
            vecMem[i] = {4'hf, 32'(i)};     // Marker nibble never used by the file
        end
        $readmemh("verif/coreVectors.mem", vecMem);
        if (vecMem[vecCount * vecWords - 1][35:32] == 4'hf)
        begin
            $display("Vector file is missing or holds fewer than %0d vectors", vecCount);
            errorCount++;
        end
        for (int pass = 0; pass < numPasses; pass++)
        begin
            applyReset();   // Same register image for every pass
            for (int v = 0; v < vecCount; v++)
            begin
                if (pass > 0 && ($random(seed) & 3) == 0)
                    stepCycle(1'b0, 32'h0);
                runVector(v);
            end
            repeat (3) stepCycle(1'b0, 32'h0);     // Drain the pipeline
        end
        $display("Retires checked: %0d, errors: %0d", retireCount, errorCount);
        if (errorCount == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

    // Watchdog
    initial
    begin
        #(timeLimit);
        $display("Timeout: the run did not finish within %0d ns", timeLimit);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verif/coreVectors.mem ====
// Columns: instruction, bubble flag, expected destination, illegal flag and data (bit 32 = illegal)
// Reset image: x1 = 7, x2 = 7, x29 = 252, all others 0
002081B3 0 03 00000000E  // add   x3,x1,x2
000E8233 0 04 0000000FC  // add   x4,x29,x0
00900293 0 05 000000009  // addi  x5,x0,9
00528333 0 06 000000012  // add   x6,x5,x5 bypass
00900513 0 0A 000000009  // addi  x10,x0,9
00000000 1 00 000000000  // bubble
00A505B3 0 0B 000000012  // add   x11,x10,x10 after bubble
FF000613 0 0C 0FFFFFFF0  // addi  x12,x0,-16
00300693 0 0D 000000003  // addi  x13,x0,3
40C68733 0 0E 000000013  // sub   x14,x13,x12
00D697B3 0 0F 000000018  // sll   x15,x13,x13
00D62833 0 10 000000001  // slt   x16,x12,x13
00D638B3 0 11 000000000  // sltu  x17,x12,x13
00D64933 0 12 0FFFFFFF3  // xor   x18,x12,x13
00D659B3 0 13 01FFFFFFE  // srl   x19,x12,x13
40D65A33 0 14 0FFFFFFFE  // sra   x20,x12,x13
00D66AB3 0 15 0FFFFFFF3  // or    x21,x12,x13
01D67B33 0 16 0000000F0  // and   x22,x12,x29
06460B93 0 17 000000054  // addi  x23,x12,100
FFF6AC13 0 18 000000000  // slti  x24,x13,-1
FFF6BC93 0 19 000000001  // sltiu x25,x13,-1
00F64D13 0 1A 0FFFFFFFF  // xori  x26,x12,15
1006ED93 0 1B 000000103  // ori   x27,x13,256
03CEFE13 0 1C 00000003C  // andi  x28,x29,60
00469F13 0 1E 000000030  // slli  x30,x13,4
00465F93 0 1F 00FFFFFFF  // srli  x31,x12,4
40265713 0 0E 0FFFFFFFC  // srai  x14,x12,2
123457B7 0 0F 012345000  // lui   x15,0x12345
00500013 0 00 000000005  // addi  x0,x0,5
00000833 0 10 000000000  // add   x16,x0,x0
00000000 1 00 000000000  // bubble
00002683 0 0D 100000000  // lw    x13 is illegal here
022086B3 0 0D 100000000  // funct7 0000001 is illegal
000688B3 0 11 000000003  // add   x17,x13,x0 sees old x13

// ==== tb.f ====
design/rvCorePkg.sv
design/AluUnit.sv
design/RegisterMemory.sv
design/InstrDecoder.sv
design/ExecuteStage.sv
design/IntegerCore.sv
verif/IntegerCoreTb.sv

// ==== Makefile ====
# Verilator build and run for the RV32I integer core testbench

VERILATOR ?= verilator
TOP       ?= IntegerCoreTb
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
VECTORS := verif/coreVectors.mem
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN) $(VECTORS)
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then echo "Run failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "SIMULATION PASSED" $(LOG); then echo "Run ended early, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
